/* common/llc_consts.svh */
// cache lookup widths and counts for the package and every RTL file that includes it
`ifndef LLC_CONSTS_SVH
`define LLC_CONSTS_SVH

// address split from msb to lsb is tag then index then offset
// byte within a cache line
`define LLC_OFFSET_W 4
// set select for 16 sets
`define LLC_INDEX_W 4
// stored tag bits
`define LLC_TAG_W 8
// full descriptor address
`define LLC_ADDR_W (`LLC_TAG_W + `LLC_INDEX_W + `LLC_OFFSET_W)

// associativity
`define LLC_WAYS 4

// descriptor id with one miss counter per id value
`define LLC_ID_W 2
// miss counter width that saturates at all ones
`define LLC_CNT_W 3

`endif

/* common/llc_pkg.sv */
// shared types of the cache lookup stage that each module imports as needed
`include "llc_consts.svh"

package llc_pkg;

  // address as seen by the tag store
  typedef struct packed {
    logic [`LLC_TAG_W-1:0]    tag;
    logic [`LLC_INDEX_W-1:0]  index;
    logic [`LLC_OFFSET_W-1:0] offset;
  } addr_fields_t;

  // same word either as a plain bus or split into fields
  typedef union packed {
    logic [`LLC_ADDR_W-1:0] raw;
    addr_fields_t           fields;
  } addr_u;

  // one-hot way select
  typedef logic [`LLC_WAYS-1:0] way_ind_t;

  // descriptor whose last four fields are written by the lookup
  typedef struct packed {
    logic [`LLC_ID_W-1:0]  id;
    addr_u                 addr;
    logic                  rw;        // 1 = write
    way_ind_t              way_ind;
    logic                  refill;
    logic                  evict;
    logic [`LLC_TAG_W-1:0] evict_tag;
  } desc_t;

  // registered answer of the tag store
  typedef struct packed {
    way_ind_t              way_ind;
    logic                  hit;
    logic                  evict;
    logic [`LLC_TAG_W-1:0] evict_tag;
  } lookup_res_t;

  // names one cache line
  typedef struct packed {
    logic [`LLC_INDEX_W-1:0] index;
    way_ind_t                way_ind;
  } lock_t;

  // miss counter event
  typedef struct packed {
    logic [`LLC_ID_W-1:0] id;
    logic                 valid;
  } cnt_t;

endpackage

/* hw/tag_store/tag_store.sv */
// tag, valid and dirty storage with reset sweep, lookup and round-robin allocation for the lookup stage
`timescale 1ns/1ns
`include "llc_consts.svh"

module tag_store
  import llc_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_valid_i,
  input  addr_u       req_addr_i,
  input  logic        req_dirty_i,
  output lookup_res_t res_o,
  output logic        init_done_o
);

  localparam int unsigned SETS  = 1 << `LLC_INDEX_W;
  localparam int unsigned PTR_W = $clog2(`LLC_WAYS);

  // storage arrays cleared by the sweep
  logic [`LLC_WAYS-1:0]  valid_q [SETS];
  logic [`LLC_WAYS-1:0]  dirty_q [SETS];
  logic [`LLC_TAG_W-1:0] tag_q   [SETS][`LLC_WAYS];
  // next victim per set
  logic [PTR_W-1:0]      ptr_q   [SETS];

  logic [`LLC_INDEX_W-1:0] sweep_idx_q;
  logic                    init_done_q;

  // request captured at acceptance and looked up one cycle later
  logic                    req_pending_q;
  addr_u                   req_addr_q;
  logic                    req_dirty_q;

  logic [`LLC_INDEX_W-1:0] idx;
  way_ind_t                hit_ways;
  logic                    hit;
  logic [PTR_W-1:0]        victim;
  way_ind_t                victim_ind;

  ////////////////////////////////////////
  // compare
  ////////////////////////////////////////
  always_comb begin
    idx = req_addr_q.fields.index;
    // all ways of the set in parallel
    for (int w = 0; w < `LLC_WAYS; w++) begin
      hit_ways[w] = valid_q[idx][w] && (tag_q[idx][w] == req_addr_q.fields.tag);
    end
    hit        = |hit_ways;
    victim     = ptr_q[idx];
    victim_ind = way_ind_t'(1) << victim;
  end

  ////////////////////////////////////////
  // sweep and request control
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sweep_idx_q   <= '0;
      init_done_q   <= 1'b0;
      req_pending_q <= 1'b0;
    end else begin
      // one set per cycle until the last set
      if (!init_done_q) begin
        sweep_idx_q <= sweep_idx_q + 1'b1;
        if (&sweep_idx_q) begin
          init_done_q <= 1'b1;
        end
      end
      req_pending_q <= req_valid_i;
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_addr_q.raw <= req_addr_i.raw;
      req_dirty_q    <= req_dirty_i;
    end
  end

  ////////////////////////////////////////
  // array update and result
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!init_done_q) begin
      // clear the swept set
      valid_q[sweep_idx_q] <= '0;
      dirty_q[sweep_idx_q] <= '0;
      ptr_q[sweep_idx_q]   <= '0;
      for (int w = 0; w < `LLC_WAYS; w++) begin
        tag_q[sweep_idx_q][w] <= '0;
      end
    end else if (req_pending_q) begin
      if (hit) begin
        // a write marks the hit line dirty
        dirty_q[idx] <= dirty_q[idx] | (hit_ways & {`LLC_WAYS{req_dirty_q}});
        res_o <= '{way_ind: hit_ways, hit: 1'b1, evict: 1'b0, evict_tag: '0};
      end else begin
        // allocate the pointed way and evict the old line if valid and dirty
        tag_q[idx][victim] <= req_addr_q.fields.tag;
        valid_q[idx]       <= valid_q[idx] | victim_ind;
        dirty_q[idx]       <= req_dirty_q ? (dirty_q[idx] | victim_ind)
                                          : (dirty_q[idx] & ~victim_ind);
        ptr_q[idx]         <= victim + 1'b1;
        res_o <= '{way_ind:   victim_ind,
                   hit:       1'b0,
                   evict:     valid_q[idx][victim] & dirty_q[idx][victim],
                   evict_tag: tag_q[idx][victim]};
      end
    end
  end

  assign init_done_o = init_done_q;

endmodule

/* hw/miss_counters.sv */
// outstanding-miss counters per descriptor id giving force-to-miss and stall for the current id
`timescale 1ns/1ns
`include "llc_consts.svh"

module miss_counters
  import llc_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  cnt_t                 cnt_up_i,
  input  cnt_t                 cnt_down_i,
  input  logic [`LLC_ID_W-1:0] query_id_i,
  output logic                 to_miss_o,
  output logic                 stall_o
);

  localparam int unsigned IDS = 1 << `LLC_ID_W;

  logic [`LLC_CNT_W-1:0] cnt_q [IDS];
  // per-id event decode
  logic [IDS-1:0]        up_sel;
  logic [IDS-1:0]        down_sel;

  always_comb begin
    up_sel   = '0;
    down_sel = '0;
    up_sel[cnt_up_i.id]     = cnt_up_i.valid;
    down_sel[cnt_down_i.id] = cnt_down_i.valid;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < IDS; i++) begin
        // up and down together cancel out
        if (up_sel[i] && !down_sel[i] && !(&cnt_q[i])) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (down_sel[i] && !up_sel[i] && (|cnt_q[i])) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // later hits must follow the misses in flight
  assign to_miss_o = |cnt_q[query_id_i];
  // full counter holds back further misses of this id
  assign stall_o   = &cnt_q[query_id_i];

endmodule

/* hw/lock_table.sv */
// one lock bit per cache line that is set when a descriptor leaves and cleared by the downstream unlock
`timescale 1ns/1ns
`include "llc_consts.svh"

module lock_table
  import llc_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  lock_t lock_i,
  input  logic  lock_set_i,
  input  lock_t unlock_i,
  input  logic  unlock_valid_i,
  input  lock_t query_i,
  output logic  locked_o
);

  localparam int unsigned SETS = 1 << `LLC_INDEX_W;

  logic [`LLC_WAYS-1:0] lock_q [SETS];
  logic [`LLC_WAYS-1:0] lock_d [SETS];

  // unlock is applied one edge after its strobe
  lock_t                unlock_q;
  logic                 unlock_pend_q;

  always_comb begin
    for (int s = 0; s < SETS; s++) begin
      lock_d[s] = lock_q[s];
      if (unlock_pend_q && (unlock_q.index == (`LLC_INDEX_W)'(s))) begin
        lock_d[s] = lock_d[s] & ~unlock_q.way_ind;
      end
      // set after clear so a colliding set wins
      if (lock_set_i && (lock_i.index == (`LLC_INDEX_W)'(s))) begin
        lock_d[s] = lock_d[s] | lock_i.way_ind;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      unlock_pend_q <= 1'b0;
      for (int s = 0; s < SETS; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      unlock_pend_q <= unlock_valid_i;
      lock_q        <= lock_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (unlock_valid_i) begin
      unlock_q <= unlock_i;
    end
  end

  // line still held by a descriptor downstream
  assign locked_o = |(lock_q[query_i.index] & query_i.way_ind);

endmodule

/* hw/hit_miss_unit.sv */
// top of the cache lookup stage that routes each descriptor to the hit or the miss port after its lookup
`timescale 1ns/1ns
`include "llc_consts.svh"

module hit_miss_unit
  import llc_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  desc_t desc_i,
  input  logic  valid_i,
  output logic  ready_o,
  output desc_t desc_o,
  output logic  hit_valid_o,
  input  logic  hit_ready_i,
  output logic  miss_valid_o,
  input  logic  miss_ready_i,
  input  lock_t unlock_i,
  input  logic  unlock_valid_i,
  input  cnt_t  cnt_down_i
);

  desc_t       desc_q;
  logic        busy_q;
  // lookup result is present for the held descriptor
  logic        lookup_done_q;
  // port frozen from the raised valid until the transfer
  logic        held_q;
  logic        held_miss_q;

  lookup_res_t lookup_res;
  logic        init_done;
  logic        locked;
  logic        stall;
  logic        to_miss;

  logic        go_miss;
  logic        out_ok;
  logic        depart;
  logic        accept;
  lock_t       lock;
  cnt_t        cnt_up;

  ////////////////////////////////////////
  // routing
  ////////////////////////////////////////
  always_comb begin
    // merge lookup result into the descriptor
    desc_o           = desc_q;
    desc_o.way_ind   = lookup_res.way_ind;
    desc_o.refill    = ~lookup_res.hit;
    desc_o.evict     = lookup_res.evict;
    desc_o.evict_tag = lookup_res.evict_tag;

    // hits of an id with misses in flight also take the miss port
    go_miss = held_q ? held_miss_q : (~lookup_res.hit | to_miss);
    out_ok  = busy_q & lookup_done_q & (held_q | ~(locked | stall));

    hit_valid_o  = out_ok & ~go_miss;
    miss_valid_o = out_ok & go_miss;
    depart       = (hit_valid_o & hit_ready_i) | (miss_valid_o & miss_ready_i);

    // next descriptor may enter as the current one leaves
    ready_o = init_done & (~busy_q | depart);
    accept  = valid_i & ready_o;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q        <= 1'b0;
      lookup_done_q <= 1'b0;
      held_q        <= 1'b0;
    end else if (accept) begin
      busy_q        <= 1'b1;
      lookup_done_q <= 1'b0;
      held_q        <= 1'b0;
    end else if (depart) begin
      busy_q        <= 1'b0;
      lookup_done_q <= 1'b0;
      held_q        <= 1'b0;
    end else begin
      // result is registered one edge after acceptance
      if (busy_q) begin
        lookup_done_q <= 1'b1;
      end
      if (out_ok) begin
        held_q <= 1'b1;
      end
    end
  end

  // descriptor and frozen port choice
  always_ff @(posedge clk_i) begin
    if (accept) begin
      desc_q <= desc_i;
    end
    if (out_ok && !held_q) begin
      held_miss_q <= go_miss;
    end
  end

  ////////////////////////////////////////
  // submodules
  ////////////////////////////////////////
  tag_store tag_store_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (accept),
    .req_addr_i  (desc_i.addr),
    .req_dirty_i (desc_i.rw),
    .res_o       (lookup_res),
    .init_done_o (init_done)
  );

  // the line leaving is the one queried
  assign lock = '{index: desc_o.addr.fields.index, way_ind: desc_o.way_ind};

  lock_table lock_table_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lock_i         (lock),
    .lock_set_i     (depart),
    .unlock_i       (unlock_i),
    .unlock_valid_i (unlock_valid_i),
    .query_i        (lock),
    .locked_o       (locked)
  );

  // count up on every miss port transfer
  assign cnt_up = '{id: desc_q.id, valid: miss_valid_o & miss_ready_i};

  miss_counters miss_counters_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cnt_up_i   (cnt_up),
    .cnt_down_i (cnt_down_i),
    .query_id_i (desc_q.id),
    .to_miss_o  (to_miss),
    .stall_o    (stall)
  );

endmodule

/* testbench/tb_clock_gen.sv */
// clock and reset source for the lookup stage testbench with a 20 ns period and a four cycle reset
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 4;

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset low for the first edges and released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* testbench/tb_hit_miss.sv */
// testbench of the cache lookup stage that replays the operation trace and checks each routed descriptor
`timescale 1ns/1ns
`include "llc_consts.svh"

module tb_hit_miss
  import llc_pkg::*;
();

  localparam string TRACE_FILE     = "testbench/hit_miss_trace.txt";
  localparam int    ACCEPT_TIMEOUT = 64;
  localparam int    OUT_TIMEOUT    = 64;
  localparam int    SWEEP_CYCLES   = 1 << `LLC_INDEX_W;
  localparam int    LOCK_WAIT      = 20;

  logic   clk;
  logic   rst_n;
  desc_t  in_desc;
  logic   in_valid;
  logic   in_ready;
  desc_t  out_desc;
  logic   hit_valid;
  logic   hit_ready;
  logic   miss_valid;
  logic   miss_ready;
  lock_t  unlock;
  logic   unlock_valid;
  cnt_t   cnt_down;

  integer seed = 32'h6039_d69e;
  // the first request also checks the reset sweep
  logic   first_req = 1'b1;

  tb_clock_gen clock_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  hit_miss_unit hit_miss_unit_inst (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .desc_i         (in_desc),
    .valid_i        (in_valid),
    .ready_o        (in_ready),
    .desc_o         (out_desc),
    .hit_valid_o    (hit_valid),
    .hit_ready_i    (hit_ready),
    .miss_valid_o   (miss_valid),
    .miss_ready_i   (miss_ready),
    .unlock_i       (unlock),
    .unlock_valid_i (unlock_valid),
    .cnt_down_i     (cnt_down)
  );

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_desc(input string name, input desc_t got, input desc_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // port selection where 1 is the miss port
  task automatic check_port(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic desc_t make_desc(input int id, input int addr, input int rw, input int way,
                                      input int refill, input int evict, input int etag);
    desc_t d;
    d.id        = id[`LLC_ID_W-1:0];
    d.addr.raw  = addr[`LLC_ADDR_W-1:0];
    d.rw        = rw[0];
    d.way_ind   = way[`LLC_WAYS-1:0];
    d.refill    = refill[0];
    d.evict     = evict[0];
    d.evict_tag = etag[`LLC_TAG_W-1:0];
    return d;
  endfunction

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////
  // offer one descriptor and wait until it is taken
  task automatic send_req(input desc_t d);
    int waited;
    int swept;
    waited = 0;
    swept  = 0;
    @(posedge clk);
    in_desc  <= d;
    in_valid <= 1'b1;
    @(negedge clk);
    while (!in_ready) begin
      // no output may be valid while nothing is held
      if (hit_valid || miss_valid) begin
        fail_run("an output valid was raised while no descriptor was held");
      end
      if (rst_n) begin
        swept++;
      end
      waited++;
      if (waited > ACCEPT_TIMEOUT) begin
        fail_run("the unit never accepted the offered descriptor");
      end
      @(negedge clk);
    end
    if (first_req && (swept < SWEEP_CYCLES)) begin
      fail_run("a descriptor was accepted before the tag sweep had ended");
    end
    first_req = 1'b0;
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // random back-pressure until the descriptor leaves with fields checked while valid
  task automatic collect_out(input desc_t exp_desc, input logic exp_miss);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk);
      hit_ready  <= ($random(seed) & 3) != 0;
      miss_ready <= ($random(seed) & 3) != 0;
      @(negedge clk);
      if (hit_valid && miss_valid) begin
        fail_run("both output ports were valid in the same cycle");
      end
      if (hit_valid || miss_valid) begin
        check_port("output port", miss_valid, exp_miss);
        check_desc("desc_o", out_desc, exp_desc);
        done = (hit_valid && hit_ready) || (miss_valid && miss_ready);
      end
      cycles++;
      if (!done && (cycles > OUT_TIMEOUT)) begin
        fail_run("no descriptor left the unit before the timeout");
      end
    end
  endtask

  // the held descriptor must not show up while its line is locked
  task automatic check_held_back();
    repeat (LOCK_WAIT) begin
      @(negedge clk);
      if (hit_valid || miss_valid) begin
        fail_run("an output valid was raised for a line that is still locked");
      end
    end
  endtask

  task automatic pulse_unlock(input lock_t l);
    @(posedge clk);
    unlock       <= l;
    unlock_valid <= 1'b1;
    @(posedge clk);
    unlock_valid <= 1'b0;
  endtask

  task automatic pulse_count_down(input cnt_t c);
    @(posedge clk);
    cnt_down <= c;
    @(posedge clk);
    cnt_down <= '0;
  endtask

  ////////////////////////////////////////
  // trace replay
  ////////////////////////////////////////
  initial begin : run_trace
    int    fd;
    int    code;
    int    req_count;
    string op;
    string rest;
    int    f_id;
    int    f_addr;
    int    f_rw;
    int    f_port;
    int    f_way;
    int    f_refill;
    int    f_evict;
    int    f_etag;
    int    f_idx;
    desc_t exp_desc;
    desc_t pend_desc;
    logic  pend_miss;
    logic  pend_valid;
    lock_t ulk;
    cnt_t  dec;

    in_desc      = '0;
    in_valid     = 1'b0;
    hit_ready    = 1'b0;
    miss_ready   = 1'b0;
    unlock       = '0;
    unlock_valid = 1'b0;
    cnt_down     = '0;
    pend_desc    = '0;
    pend_miss    = 1'b0;
    pend_valid   = 1'b0;
    req_count    = 0;

    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      fail_run("the trace file could not be opened");
    end
    code = $fscanf(fd, "%s", op);
    while (code == 1) begin
      if (op == "#") begin
        void'($fgets(rest, fd));
      end else if ((op == "R") || (op == "S")) begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                       f_id, f_addr, f_rw, f_port, f_way, f_refill, f_evict, f_etag);
        if (code != 8) begin
          fail_run("a request line of the trace is incomplete");
        end
        exp_desc = make_desc(f_id, f_addr, f_rw, f_way, f_refill, f_evict, f_etag);
        // lookup fields go in cleared for the unit to fill
        send_req(make_desc(f_id, f_addr, f_rw, 0, 0, 0, 0));
        req_count++;
        if (op == "R") begin
          collect_out(exp_desc, f_port[0]);
        end else begin
          check_held_back();
          pend_desc  = exp_desc;
          pend_miss  = f_port[0];
          pend_valid = 1'b1;
        end
      end else if (op == "U") begin
        code = $fscanf(fd, "%h %h", f_idx, f_way);
        if (code != 2) begin
          fail_run("an unlock line of the trace is incomplete");
        end
        ulk.index   = f_idx[`LLC_INDEX_W-1:0];
        ulk.way_ind = f_way[`LLC_WAYS-1:0];
        pulse_unlock(ulk);
        // a waiting request may leave now
        if (pend_valid) begin
          collect_out(pend_desc, pend_miss);
          pend_valid = 1'b0;
        end
      end else if (op == "C") begin
        code = $fscanf(fd, "%h", f_id);
        if (code != 1) begin
          fail_run("a count-down line of the trace is incomplete");
        end
        dec.id    = f_id[`LLC_ID_W-1:0];
        dec.valid = 1'b1;
        pulse_count_down(dec);
      end else begin
        fail_run("the trace holds an unknown operation");
      end
      code = $fscanf(fd, "%s", op);
    end
    $fclose(fd);

    if (pend_valid) begin
      fail_run("a waiting request was never released by the trace");
    end
    if (req_count == 0) begin
      fail_run("the trace held no requests");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

/* testbench/hit_miss_trace.txt */
# R or S: id addr rw port(0 hit 1 miss) way_ind refill evict evict_tag, all hex, S waits on a lock
# U: index way_ind (unlock one line)   C: id (count one miss down)
# cold miss right after the sweep, then a hit on the same line
R 0 1230 0 1 1 1 0 00
U 3 1
C 0
R 0 1238 0 0 1 0 0 00
U 3 1
# id 1 has a miss in flight, its hit goes out on the miss port, id 2 does not
R 1 4050 0 1 1 1 0 00
R 1 1234 0 1 1 0 0 00
U 3 1
R 2 123c 0 0 1 0 0 00
U 3 1
# line of set 5 way 0 still locked, id 3 waits for the unlock
S 3 4054 0 0 1 0 0 00
U 5 1
U 5 1
C 1
C 1
# four write misses fill set 9, the fifth tag evicts the first dirty line
R 0 a090 1 1 1 1 0 00
U 9 1
C 0
R 0 b090 1 1 2 1 0 00
U 9 2
C 0
R 0 c090 1 1 4 1 0 00
U 9 4
C 0
R 0 d090 1 1 8 1 0 00
U 9 8
C 0
R 0 e090 1 1 1 1 1 a0
U 9 1
C 0

/* sources.f */
+incdir+common
common/llc_pkg.sv
hw/tag_store/tag_store.sv
hw/miss_counters.sv
hw/lock_table.sv
hw/hit_miss_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_hit_miss.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module tb_hit_miss -Mdir obj_dir > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_hit_miss > sim.log 2>&1 || echo "simulator returned an error status"
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
  || { echo "no pass message in sim.log"; exit 1; }
